//--- files.f
hw/arm_pkg.sv
hw/cond_check.sv
hw/operand_shifter.sv
hw/arm_alu.sv
hw/register_file.sv
hw/arm_decoder.sv
hw/instruction_sequencer.sv
hw/arm_core.sv
testbench/tb_arm_core.sv

//--- hw/arm_alu.sv
// ALU with NZCV generation
module arm_alu (
    input  arm_pkg::alu_op_e i_op,
    input  arm_pkg::word_t   i_x,
    input  arm_pkg::word_t   i_y,
    input  arm_pkg::nzcv_t   i_nzcv,
    output arm_pkg::word_t   o_res,
    output arm_pkg::nzcv_t   o_nzcv
);
    import arm_pkg::*;

    logic [32:0] add_sum;
    logic [32:0] sub_sum;
    logic        c;
    logic        v;

    assign add_sum = {1'b0, i_x} + {1'b0, i_y};
    assign sub_sum = {1'b0, i_x} + {1'b0, ~i_y} + 33'd1;  // Carry out is NOT borrow

    always_comb begin
        o_res = '0;
        c     = i_nzcv[1];  // Kept for logical ops
        v     = i_nzcv[0];
        case (i_op)
            ALU_MOV: o_res = i_y;
            ALU_MVN: o_res = ~i_y;
            ALU_AND: o_res = i_x & i_y;
            ALU_ORR: o_res = i_x | i_y;
            ALU_EOR: o_res = i_x ^ i_y;
            ALU_ADD: begin
                o_res = add_sum[31:0];
                c     = add_sum[32];
                v     = (i_x[31] == i_y[31]) && (add_sum[31] != i_x[31]);
            end
            ALU_SUB: begin
                o_res = sub_sum[31:0];
                c     = sub_sum[32];
                v     = (i_x[31] != i_y[31]) && (sub_sum[31] != i_x[31]);
            end
            default: o_res = '0;
        endcase
    end

    assign o_nzcv = {o_res[31], (o_res == '0), c, v};

endmodule

//--- hw/arm_core.sv
// ARM32 multi-cycle core
module arm_core (
    input  logic             clk,
    input  logic             reset_n,
    input  arm_pkg::word_t   i_mem_rdata,
    output arm_pkg::mem_req_t o_mem,
    output logic             o_trap
);
    import arm_pkg::*;

    word_t     ins;
    nzcv_t     nzcv;
    ctrl_t     ctrl;
    reg_addr_t rn;
    reg_addr_t rm;
    reg_addr_t rd;
    imm12_t    imm12;
    imm24_t    imm24;
    word_t     v_rn;
    word_t     v_rm;
    word_t     operand;
    word_t     alu_res;
    nzcv_t     alu_nzcv;
    logic      wb_en;
    reg_addr_t wb_addr;
    word_t     wb_data;

    instruction_sequencer u_seq (
        .clk         (clk),
        .reset_n     (reset_n),
        .i_mem_rdata (i_mem_rdata),
        .i_ctrl      (ctrl),
        .i_alu_res   (alu_res),
        .i_alu_nzcv  (alu_nzcv),
        .i_imm24     (imm24),
        .i_v_store   (v_rm),       // Rd value for STR
        .i_rd        (rd),
        .o_ins       (ins),
        .o_nzcv      (nzcv),
        .o_mem       (o_mem),
        .o_wb_en     (wb_en),
        .o_wb_addr   (wb_addr),
        .o_wb_data   (wb_data),
        .o_trap      (o_trap)
    );

    arm_decoder u_dec (
        .i_ins   (ins),
        .i_nzcv  (nzcv),
        .o_ctrl  (ctrl),
        .o_rn    (rn),
        .o_rm    (rm),
        .o_rd    (rd),
        .o_imm12 (imm12),
        .o_imm24 (imm24)
    );

    register_file u_rf (
        .clk       (clk),
        .reset_n   (reset_n),
        .i_r_addr1 (rn),
        .i_r_addr2 (rm),
        .i_w_addr  (wb_addr),
        .i_w_data  (wb_data),
        .i_w_en    (wb_en),
        .o_v1      (v_rn),
        .o_v2      (v_rm)
    );

    operand_shifter u_shift (
        .i_v_rm    (v_rm),
        .i_imm12   (imm12),
        .i_ctrl    (ctrl),
        .o_operand (operand)
    );

    arm_alu u_alu (
        .i_op   (ctrl.alu_op),
        .i_x    (v_rn),
        .i_y    (operand),
        .i_nzcv (nzcv),
        .o_res  (alu_res),
        .o_nzcv (alu_nzcv)
    );

endmodule

//--- hw/arm_decoder.sv
// ARM32 instruction decoder
module arm_decoder (
    input  arm_pkg::word_t     i_ins,
    input  arm_pkg::nzcv_t     i_nzcv,
    output arm_pkg::ctrl_t     o_ctrl,
    output arm_pkg::reg_addr_t o_rn,
    output arm_pkg::reg_addr_t o_rm,
    output arm_pkg::reg_addr_t o_rd,
    output arm_pkg::imm12_t    o_imm12,
    output arm_pkg::imm24_t    o_imm24
);
    import arm_pkg::*;

    logic [1:0] cls;
    logic [3:0] opc;
    logic       i_bit;
    logic       s_bit;       // Also the L bit of LDR/STR
    logic       pass;
    ctrl_t      ctrl;

    assign cls   = i_ins[27:26];
    assign i_bit = i_ins[25];
    assign opc   = i_ins[24:21];
    assign s_bit = i_ins[20];

    cond_check u_cond (
        .i_cond (i_ins[31:28]),
        .i_nzcv (i_nzcv),
        .o_pass (pass)
    );

    always_comb begin
        ctrl = '0;
        case (cls)
            CLASS_DP: begin
                ctrl.imm       = i_bit;
                ctrl.set_flags = s_bit;
                ctrl.wb_en     = 1'b1;
                case (opc)
                    OPC_AND: ctrl.alu_op = ALU_AND;
                    OPC_EOR: ctrl.alu_op = ALU_EOR;
                    OPC_SUB: ctrl.alu_op = ALU_SUB;
                    OPC_ADD: ctrl.alu_op = ALU_ADD;
                    OPC_ORR: ctrl.alu_op = ALU_ORR;
                    OPC_MOV: ctrl.alu_op = ALU_MOV;
                    OPC_MVN: ctrl.alu_op = ALU_MVN;
                    OPC_TST: begin
                        ctrl.alu_op    = ALU_AND;
                        ctrl.wb_en     = 1'b0;
                        ctrl.set_flags = 1'b1;
                    end
                    OPC_CMP: begin
                        ctrl.alu_op    = ALU_SUB;
                        ctrl.wb_en     = 1'b0;
                        ctrl.set_flags = 1'b1;
                    end
                    default: begin  // Unsupported opcode has no effect
                        ctrl.wb_en     = 1'b0;
                        ctrl.set_flags = 1'b0;
                    end
                endcase
            end
            CLASS_MEM: begin
                ctrl.alu_op   = ALU_ADD;  // Base plus offset
                ctrl.mem_r_en = s_bit;
                ctrl.mem_w_en = ~s_bit;
                ctrl.wb_en    = s_bit;
            end
            CLASS_BR:  ctrl.br   = 1'b1;
            CLASS_COP: ctrl.trap = 1'b1;
            default: ;
        endcase
    end

    always_comb begin
        o_ctrl = ctrl;
        if (!pass) begin
            o_ctrl      = '0;
            o_ctrl.trap = ctrl.trap;  // Trap ignores the condition
        end
    end

    assign o_rn    = i_ins[19:16];
    assign o_rd    = i_ins[15:12];
    assign o_rm    = (cls == CLASS_MEM && !s_bit) ? i_ins[15:12] : i_ins[3:0];
    assign o_imm12 = i_ins[11:0];
    assign o_imm24 = i_ins[23:0];

endmodule

//--- hw/arm_pkg.sv
// ARM32 core shared definitions
package arm_pkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  reg_addr_t;
    typedef logic [3:0]  nzcv_t;   // N, Z, C, V
    typedef logic [11:0] imm12_t;
    typedef logic [23:0] imm24_t;

    typedef enum logic [3:0] {
        ALU_MOV,
        ALU_MVN,
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_ORR,
        ALU_EOR
    } alu_op_e;

    typedef enum logic [2:0] {
        STEP_FETCH,
        STEP_DECODE,
        STEP_EXECUTE,
        STEP_MEMORY,
        STEP_WRITEBACK,
        STEP_HALT
    } step_e;

    typedef struct packed {
        alu_op_e alu_op;
        logic    wb_en;      // Write Rd
        logic    set_flags;  // S bit or CMP/TST
        logic    imm;        // Rotated immediate operand
        logic    mem_r_en;
        logic    mem_w_en;
        logic    br;
        logic    trap;
    } ctrl_t;

    typedef struct packed {
        word_t addr;
        word_t wdata;
        logic  we;
        logic  re;
    } mem_req_t;

    localparam logic [1:0] CLASS_DP  = 2'b00;
    localparam logic [1:0] CLASS_MEM = 2'b01;
    localparam logic [1:0] CLASS_BR  = 2'b10;
    localparam logic [1:0] CLASS_COP = 2'b11;

    localparam logic [3:0] OPC_AND = 4'h0;
    localparam logic [3:0] OPC_EOR = 4'h1;
    localparam logic [3:0] OPC_SUB = 4'h2;
    localparam logic [3:0] OPC_ADD = 4'h4;
    localparam logic [3:0] OPC_TST = 4'h8;
    localparam logic [3:0] OPC_CMP = 4'ha;
    localparam logic [3:0] OPC_ORR = 4'hc;
    localparam logic [3:0] OPC_MOV = 4'hd;
    localparam logic [3:0] OPC_MVN = 4'hf;

    localparam logic [1:0] SH_LSL = 2'b00;
    localparam logic [1:0] SH_LSR = 2'b01;
    localparam logic [1:0] SH_ASR = 2'b10;
    localparam logic [1:0] SH_ROR = 2'b11;

    localparam logic [3:0] COND_EQ = 4'h0;
    localparam logic [3:0] COND_NE = 4'h1;
    localparam logic [3:0] COND_CS = 4'h2;
    localparam logic [3:0] COND_CC = 4'h3;
    localparam logic [3:0] COND_MI = 4'h4;
    localparam logic [3:0] COND_PL = 4'h5;
    localparam logic [3:0] COND_VS = 4'h6;
    localparam logic [3:0] COND_VC = 4'h7;
    localparam logic [3:0] COND_HI = 4'h8;
    localparam logic [3:0] COND_LS = 4'h9;
    localparam logic [3:0] COND_GE = 4'ha;
    localparam logic [3:0] COND_LT = 4'hb;
    localparam logic [3:0] COND_GT = 4'hc;
    localparam logic [3:0] COND_LE = 4'hd;
    localparam logic [3:0] COND_AL = 4'he;
    localparam logic [3:0] COND_NV = 4'hf;

    localparam word_t PC_STEP  = 32'd4;
    localparam word_t PC_AHEAD = 32'd8;  // PC reads two words ahead
    localparam word_t RESET_PC = 32'd0;

endpackage

//--- hw/cond_check.sv
// Condition code check
module cond_check (
    input  logic [3:0]     i_cond,
    input  arm_pkg::nzcv_t i_nzcv,
    output logic           o_pass
);
    import arm_pkg::*;

    logic n;
    logic z;
    logic c;
    logic v;

    assign {n, z, c, v} = i_nzcv;

    always_comb begin
        o_pass = 1'b0;
        case (i_cond)
            COND_EQ: o_pass = z;
            COND_NE: o_pass = ~z;
            COND_CS: o_pass = c;
            COND_CC: o_pass = ~c;
            COND_MI: o_pass = n;
            COND_PL: o_pass = ~n;
            COND_VS: o_pass = v;
            COND_VC: o_pass = ~v;
            COND_HI: o_pass = c & ~z;
            COND_LS: o_pass = ~c | z;
            COND_GE: o_pass = (n == v);
            COND_LT: o_pass = (n != v);
            COND_GT: o_pass = ~z & (n == v);
            COND_LE: o_pass = z | (n != v);
            COND_AL: o_pass = 1'b1;
            COND_NV: o_pass = 1'b0;
            default: o_pass = 1'b0;
        endcase
    end

endmodule

//--- hw/instruction_sequencer.sv
// Instruction step sequencer
module instruction_sequencer (
    input  logic               clk,
    input  logic               reset_n,
    input  arm_pkg::word_t     i_mem_rdata,
    input  arm_pkg::ctrl_t     i_ctrl,
    input  arm_pkg::word_t     i_alu_res,
    input  arm_pkg::nzcv_t     i_alu_nzcv,
    input  arm_pkg::imm24_t    i_imm24,
    input  arm_pkg::word_t     i_v_store,
    input  arm_pkg::reg_addr_t i_rd,
    output arm_pkg::word_t     o_ins,
    output arm_pkg::nzcv_t     o_nzcv,
    output arm_pkg::mem_req_t  o_mem,
    output logic               o_wb_en,
    output arm_pkg::reg_addr_t o_wb_addr,
    output arm_pkg::word_t     o_wb_data,
    output logic               o_trap
);
    import arm_pkg::*;

    step_e     step_q;
    word_t     pc_q;
    nzcv_t     nzcv_q;
    ctrl_t     ctrl_q;
    logic      run_q;       // Low for the first cycle after reset

    word_t     ins_q;
    word_t     alu_q;
    nzcv_t     alu_nzcv_q;
    word_t     target_q;
    word_t     store_q;
    reg_addr_t rd_q;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            step_q <= STEP_FETCH;
            pc_q   <= RESET_PC;
            nzcv_q <= '0;
            ctrl_q <= '0;
            run_q  <= 1'b0;
        end else begin
            run_q <= 1'b1;
            case (step_q)
                STEP_FETCH: begin
                    if (run_q) begin
                        step_q <= STEP_DECODE;
                    end
                end
                STEP_DECODE:  step_q <= STEP_EXECUTE;
                STEP_EXECUTE: begin
                    ctrl_q <= i_ctrl;
                    step_q <= STEP_MEMORY;
                end
                STEP_MEMORY:  step_q <= STEP_WRITEBACK;
                STEP_WRITEBACK: begin
                    if (ctrl_q.set_flags) begin
                        nzcv_q <= alu_nzcv_q;
                    end
                    pc_q   <= ctrl_q.br ? target_q : pc_q + PC_STEP;
                    step_q <= ctrl_q.trap ? STEP_HALT : STEP_FETCH;
                end
                default: step_q <= STEP_HALT;  // Halted until reset
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (step_q == STEP_DECODE) begin
            ins_q <= i_mem_rdata;  // Fetch data arrives here
        end
        if (step_q == STEP_EXECUTE) begin
            alu_q      <= i_alu_res;
            alu_nzcv_q <= i_alu_nzcv;
            target_q   <= pc_q + PC_AHEAD + {{6{i_imm24[23]}}, i_imm24, 2'b00};
            store_q    <= i_v_store;
            rd_q       <= i_rd;
        end
    end

    always_comb begin
        o_mem.addr  = pc_q;
        o_mem.wdata = store_q;
        o_mem.re    = 1'b0;
        o_mem.we    = 1'b0;
        case (step_q)
            STEP_FETCH: o_mem.re = run_q;
            STEP_MEMORY: begin
                o_mem.addr = {alu_q[31:2], 2'b00};
                o_mem.re   = ctrl_q.mem_r_en;
                o_mem.we   = ctrl_q.mem_w_en;
            end
            default: ;
        endcase
    end

    assign o_wb_en   = (step_q == STEP_WRITEBACK) && ctrl_q.wb_en;
    assign o_wb_addr = rd_q;
    assign o_wb_data = ctrl_q.mem_r_en ? i_mem_rdata : alu_q;  // Load data in WB cycle
    assign o_ins     = ins_q;
    assign o_nzcv    = nzcv_q;
    assign o_trap    = (step_q == STEP_HALT);

endmodule

//--- hw/operand_shifter.sv
// Second operand generator
module operand_shifter (
    input  arm_pkg::word_t  i_v_rm,
    input  arm_pkg::imm12_t i_imm12,
    input  arm_pkg::ctrl_t  i_ctrl,
    output arm_pkg::word_t  o_operand
);
    import arm_pkg::*;

    logic [4:0] shift_amt;
    logic [1:0] shift_type;
    logic [4:0] rot_amt;

    function automatic word_t ror32(input word_t value, input logic [4:0] amount);
        logic [63:0] doubled;
        doubled = {value, value} >> amount;
        return doubled[31:0];
    endfunction

    assign shift_amt  = i_imm12[11:7];
    assign shift_type = i_imm12[6:5];
    assign rot_amt    = {i_imm12[11:8], 1'b0};  // Twice the rotate field

    always_comb begin
        if (i_ctrl.mem_r_en || i_ctrl.mem_w_en) begin
            o_operand = {20'b0, i_imm12};
        end else if (i_ctrl.imm) begin
            o_operand = ror32({24'b0, i_imm12[7:0]}, rot_amt);
        end else begin
            case (shift_type)
                SH_LSL:  o_operand = i_v_rm << shift_amt;
                SH_LSR:  o_operand = i_v_rm >> shift_amt;
                SH_ASR:  o_operand = word_t'($signed(i_v_rm) >>> shift_amt);
                SH_ROR:  o_operand = ror32(i_v_rm, shift_amt);
                default: o_operand = i_v_rm;
            endcase
        end
    end

endmodule

//--- hw/register_file.sv
// General purpose register file
module register_file (
    input  logic               clk,
    input  logic               reset_n,
    input  arm_pkg::reg_addr_t i_r_addr1,
    input  arm_pkg::reg_addr_t i_r_addr2,
    input  arm_pkg::reg_addr_t i_w_addr,
    input  arm_pkg::word_t     i_w_data,
    input  logic               i_w_en,
    output arm_pkg::word_t     o_v1,
    output arm_pkg::word_t     o_v2
);
    import arm_pkg::*;

    word_t regs [16];  // R15 is not the fetch PC

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (i_w_en) begin
            regs[i_w_addr] <= i_w_data;
        end
    end

    assign o_v1 = regs[i_r_addr1];
    assign o_v2 = regs[i_r_addr2];

endmodule

//--- testbench/tb_arm_core.sv
// ARM32 core testbench
module tb_arm_core;
    timeunit 1ns;
    timeprecision 1ps;
    import arm_pkg::*;

    localparam int MAX_INSTR   = 358;  // Executed instructions over all programs
    localparam int CYCLE_LIMIT = MAX_INSTR * 5 + 200;
    localparam int MEM_WORDS   = 1024;

    logic     clk;
    logic     reset_n;
    word_t    mem_rdata;
    mem_req_t mem_req;
    logic     trap;

    word_t mem [MEM_WORDS];
    word_t prog[$];
    word_t exp_addr[$];
    word_t exp_data[$];
    word_t st_addr[$];
    word_t st_data[$];
    word_t r_addr[$];
    int    r_cycle[$];
    int    cycle;
    int    seed;
    nzcv_t model_flags;

    arm_core uut (
        .clk         (clk),
        .reset_n     (reset_n),
        .i_mem_rdata (mem_rdata),
        .o_mem       (mem_req),
        .o_trap      (trap)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_value(input logic ok, input string what);
        assert (ok) else begin
            $display("Fail %0t: %s", $time, what);
            $display("TESTS FAILED");
            $fatal(1);
        end
    endtask

    task automatic require(input logic ok, input string what);
        assert (ok) else begin
            $display("%s", what);
            $display("TESTS FAILED");
            $fatal(1);
        end
    endtask

    // Memory with one cycle of read latency
    always @(posedge clk) begin : bus_model
        mem_req_t req;
        logic     rst_ok;
        req    = mem_req;
        rst_ok = reset_n;
        cycle++;
        require(cycle <= CYCLE_LIMIT, "Timeout: the simulation ran past its cycle limit");
        require(!(req.re && req.we), "Read and write strobes were high together");
        #2;
        if (rst_ok && req.re) begin
            mem_rdata = mem[req.addr[11:2]];
            r_addr.push_back(req.addr);
            r_cycle.push_back(cycle);
        end
        if (rst_ok && req.we) begin
            mem[req.addr[11:2]] = req.wdata;
            st_addr.push_back(req.addr);
            st_data.push_back(req.wdata);
        end
    end

    function automatic word_t dp(input logic [3:0] c, input logic i, input logic [3:0] opc,
                                 input logic s, input reg_addr_t rn, input reg_addr_t rd,
                                 input imm12_t op2);
        return {c, CLASS_DP, i, opc, s, rn, rd, op2};
    endfunction

    function automatic word_t mem_op(input logic [3:0] c, input logic l, input reg_addr_t rn,
                                     input reg_addr_t rd, input imm12_t off);
        return {c, CLASS_MEM, 1'b0, 4'b0000, l, rn, rd, off};
    endfunction

    function automatic word_t branch(input logic [3:0] c, input imm24_t off);
        return {c, CLASS_BR, 2'b10, off};
    endfunction

    function automatic word_t branch_target(input word_t a, input int off);
        return a + 8 + off * 4;
    endfunction

    function automatic word_t shifted_operand(input word_t v, input logic [1:0] t, input int a);
        case (t)
            2'd0:    return v << a;
            2'd1:    return v >> a;
            2'd2:    return $signed(v) >>> a;
            default: return (a == 0) ? v : ((v >> a) | (v << (32 - a)));
        endcase
    endfunction

    function automatic word_t rotated_imm(input imm12_t f);
        return shifted_operand({24'h0, f[7:0]}, 2'd3, 2 * f[11:8]);
    endfunction

    // NZCV above the 32-bit result
    function automatic logic [35:0] expected_alu(input logic [3:0] opc, input word_t x,
                                                 input word_t y, input nzcv_t f);
        logic [32:0] w;
        word_t       r;
        logic        c;
        logic        v;
        c = f[1];
        v = f[0];
        case (opc)
            OPC_ADD: begin
                w = {1'b0, x} + {1'b0, y};
                r = w[31:0];
                c = w[32];
                v = (x[31] == y[31]) && (r[31] != x[31]);
            end
            OPC_SUB, OPC_CMP: begin
                r = x - y;
                c = (x >= y);
                v = (x[31] != y[31]) && (r[31] != x[31]);
            end
            OPC_AND, OPC_TST: r = x & y;
            OPC_EOR:          r = x ^ y;
            OPC_ORR:          r = x | y;
            OPC_MOV:          r = y;
            OPC_MVN:          r = ~y;
            default:          r = '0;
        endcase
        return {r[31], (r == 0), c, v, r};
    endfunction

    function automatic logic cond_passes(input logic [3:0] c, input nzcv_t f);
        case (c)
            4'h0: return f[2];
            4'h1: return !f[2];
            4'h2: return f[1];
            4'h3: return !f[1];
            4'h4: return f[3];
            4'h5: return !f[3];
            4'h6: return f[0];
            4'h7: return !f[0];
            4'h8: return f[1] && !f[2];
            4'h9: return !f[1] || f[2];
            4'ha: return f[3] == f[0];
            4'hb: return f[3] != f[0];
            4'hc: return !f[2] && (f[3] == f[0]);
            4'hd: return f[2] || (f[3] != f[0]);
            4'he: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    task automatic emit(input word_t w);
        prog.push_back(w);
    endtask

    task automatic emit_const(input reg_addr_t rd, input word_t value);
        emit(dp(COND_AL, 1'b1, OPC_MOV, 1'b0, 4'd0, rd, {4'd4, value[31:24]}));
        emit(dp(COND_AL, 1'b1, OPC_ORR, 1'b0, rd, rd, {4'd8, value[23:16]}));
        emit(dp(COND_AL, 1'b1, OPC_ORR, 1'b0, rd, rd, {4'd12, value[15:8]}));
        emit(dp(COND_AL, 1'b1, OPC_ORR, 1'b0, rd, rd, {4'd0, value[7:0]}));
    endtask

    task automatic store_word(input reg_addr_t rd, input int off, input word_t value);
        emit(mem_op(COND_AL, 1'b0, 4'd0, rd, off[11:0]));
        exp_addr.push_back(off);
        exp_data.push_back(value);
    endtask

    task automatic new_program();
        prog.delete();
        exp_addr.delete();
        exp_data.delete();
        emit(dp(COND_AL, 1'b1, OPC_MOV, 1'b0, 4'd0, 4'd0, 12'h000));  // R0 = 0
    endtask

    task automatic load_program();
        emit({COND_AL, CLASS_COP, 26'h0});
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = 32'hc0de0000 ^ i;
        end
        foreach (prog[i]) begin
            mem[i] = prog[i];
        end
    endtask

    task automatic execute();
        int n;
        @(posedge clk);
        #2 reset_n = 1'b0;
        repeat (10) begin
            @(posedge clk);
            #1;
            require(!mem_req.re && !mem_req.we && !trap, "Strobe or trap seen during reset");
        end
        #1 reset_n = 1'b1;
        r_addr.delete();
        r_cycle.delete();
        st_addr.delete();
        st_data.delete();
        n = 0;
        while (!trap) begin
            @(posedge clk);
            #1;
            n++;
            require(n < 1500, "The core never reached the trap instruction");
        end
    endtask

    task automatic check_stores();
        check_value(st_addr.size() == exp_addr.size(), "wrong number of stores");
        foreach (exp_addr[i]) begin
            check_value(st_addr[i] == exp_addr[i], $sformatf("store %0d address %h", i, st_addr[i]));
            check_value(st_data[i] == exp_data[i], $sformatf("store %0d data %h", i, st_data[i]));
            check_value(mem[exp_addr[i][11:2]] == exp_data[i], "memory word after store");
        end
    endtask

    task automatic reset_and_fetch();
        new_program();
        emit(dp(COND_AL, 1'b1, OPC_MOV, 1'b0, 4'd0, 4'd1, 12'h001));
        emit(dp(COND_AL, 1'b1, OPC_ADD, 1'b0, 4'd1, 4'd1, 12'h001));
        load_program();
        execute();
        check_value(r_addr.size() == prog.size(), "fetch count");
        foreach (r_addr[i]) begin
            check_value(r_addr[i] == 4 * i, $sformatf("fetch address %h", r_addr[i]));
            if (i > 0) begin
                check_value(r_cycle[i] - r_cycle[i - 1] == 5, "fetch spacing");
            end
        end
    endtask

    task automatic data_processing();
        logic [3:0]  ops [6];
        word_t       a;
        word_t       b;
        int          k;
        imm12_t      f;
        logic [35:0] res;
        ops = '{OPC_ADD, OPC_SUB, OPC_AND, OPC_ORR, OPC_EOR, OPC_MVN};
        new_program();
        for (int r = 0; r < 3; r++) begin
            a = $random(seed);
            b = $random(seed);
            emit_const(4'd1, a);
            emit_const(4'd2, b);
            for (int j = 0; j < 6; j++) begin
                k = $unsigned($random(seed)) % 32;
                emit(dp(COND_AL, 1'b0, ops[j], 1'b0, 4'd1, 4'd3,
                        {k[4:0], 2'(j % 4), 1'b0, 4'd2}));
                res = expected_alu(ops[j], a, shifted_operand(b, 2'(j % 4), k), 4'h0);
                store_word(4'd3, 'h200 + r * 64 + j * 4, res[31:0]);
            end
            f = $random(seed);
            emit(dp(COND_AL, 1'b1, OPC_MOV, 1'b0, 4'd0, 4'd3, f));
            store_word(4'd3, 'h200 + r * 64 + 24, rotated_imm(f));
        end
        load_program();
        execute();
        check_stores();
    endtask

    task automatic cond_sweep(input int s);
        logic [7:0] mk;
        int         off;
        for (int c = 0; c < 16; c++) begin
            mk  = s * 16 + c + 1;
            off = 'h400 + s * 64 + c * 4;
            emit(dp(4'(c), 1'b1, OPC_MOV, 1'b0, 4'd0, 4'd5, {4'd0, mk}));
            emit(mem_op(4'(c), 1'b0, 4'd0, 4'd5, off[11:0]));
            if (cond_passes(4'(c), model_flags)) begin
                exp_addr.push_back(off);
                exp_data.push_back({24'h0, mk});
            end
        end
    endtask

    task automatic flag_case(input logic [3:0] opc, input word_t a, input word_t b, input int s);
        logic [35:0] res;
        emit_const(4'd1, a);
        emit_const(4'd2, b);
        emit(dp(COND_AL, 1'b0, opc, 1'b1, 4'd1, 4'd3, 12'h002));
        res = expected_alu(opc, a, b, model_flags);
        model_flags = res[35:32];
        cond_sweep(s);
    endtask

    task automatic flags_and_conditions();
        logic [35:0] t;
        new_program();
        model_flags = 4'h0;
        flag_case(OPC_CMP, 32'd1, 32'd1, 0);
        flag_case(OPC_CMP, 32'd1, 32'd2, 1);
        flag_case(OPC_ADD, 32'h7fffffff, 32'd1, 2);
        flag_case(OPC_CMP, 32'd2, 32'd1, 3);
        flag_case(OPC_ADD, 32'h80000000, 32'h80000000, 4);
        emit(dp(COND_AL, 1'b0, OPC_TST, 1'b1, 4'd1, 4'd0, 12'h002));
        t = expected_alu(OPC_AND, 32'h80000000, 32'h80000000, model_flags);
        model_flags = {t[35:34], model_flags[1:0]};  // TST leaves C and V
        cond_sweep(5);
        load_program();
        execute();
        check_stores();
    endtask

    task automatic load_and_store();
        word_t pre [4];
        word_t k;
        new_program();
        k = $random(seed);
        emit_const(4'd6, 32'h300);
        emit_const(4'd7, k);
        for (int i = 0; i < 4; i++) begin
            pre[i] = $random(seed);
            emit(mem_op(COND_AL, 1'b1, 4'd6, 4'd3, 12'(i * 4)));
            emit(dp(COND_AL, 1'b0, OPC_ADD, 1'b0, 4'd3, 4'd3, 12'h007));
            emit(mem_op(COND_AL, 1'b0, 4'd6, 4'd3, 12'('h80 + i * 4)));
            exp_addr.push_back('h380 + i * 4);
            exp_data.push_back(pre[i] + k);
        end
        load_program();
        for (int i = 0; i < 4; i++) begin
            mem[('h300 >> 2) + i] = pre[i];
        end
        execute();
        check_stores();
    endtask

    task automatic branch_and_skip();
        word_t fetch_exp[$];
        word_t lp;
        prog.delete();
        exp_addr.delete();
        exp_data.delete();
        emit(dp(COND_AL, 1'b1, OPC_MOV, 1'b0, 4'd0, 4'd1, 12'h005));  // 0x00
        emit(dp(COND_AL, 1'b1, OPC_MOV, 1'b0, 4'd0, 4'd2, 12'h000));  // 0x04
        emit(dp(COND_AL, 1'b1, OPC_SUB, 1'b1, 4'd1, 4'd1, 12'h001));  // 0x08 loop
        emit(dp(COND_AL, 1'b1, OPC_ADD, 1'b0, 4'd2, 4'd2, 12'h003));  // 0x0c
        emit(branch(COND_NE, 24'hfffffc));                             // 0x10
        store_word(4'd2, 'h400, 32'd15);                               // 0x14
        emit(branch(COND_AL, 24'h000001));                             // 0x18
        emit(mem_op(COND_AL, 1'b0, 4'd0, 4'd2, 12'h404));              // Skipped
        emit(mem_op(COND_AL, 1'b0, 4'd0, 4'd1, 12'h40c));              // Skipped
        store_word(4'd1, 'h408, 32'd0);                                // 0x24
        load_program();
        lp = branch_target(32'h10, -4);
        fetch_exp = '{32'h0, 32'h4};
        repeat (5) begin
            fetch_exp.push_back(lp);
            fetch_exp.push_back(lp + 4);
            fetch_exp.push_back(lp + 8);
        end
        fetch_exp.push_back(32'h14);
        fetch_exp.push_back(32'h18);
        fetch_exp.push_back(branch_target(32'h18, 1));
        fetch_exp.push_back(branch_target(32'h18, 1) + 4);
        execute();
        check_value(r_addr.size() == fetch_exp.size(), "fetch count with branches");
        foreach (fetch_exp[i]) begin
            check_value(r_addr[i] == fetch_exp[i], $sformatf("fetch %0d at %h", i, r_addr[i]));
        end
        check_stores();
    endtask

    task automatic trap_halt();
        int n_reads;
        int n_stores;
        new_program();
        emit(dp(COND_AL, 1'b1, OPC_MOV, 1'b0, 4'd0, 4'd1, 12'h007));
        load_program();
        emit(mem_op(COND_AL, 1'b0, 4'd0, 4'd1, 12'h500));  // After the trap
        mem[prog.size() - 1] = prog[prog.size() - 1];
        execute();
        n_reads  = r_addr.size();
        n_stores = st_addr.size();
        repeat (20) begin
            @(posedge clk);
            #1;
            check_value(trap, "trap output dropped");
        end
        check_value(r_addr.size() == n_reads, "fetch strobe after trap");
        check_value(st_addr.size() == n_stores, "store strobe after trap");
        check_stores();
    endtask

    initial begin
        seed      = 32'h76f0;
        reset_n   = 1'b0;
        mem_rdata = '0;
        cycle     = 0;
        reset_and_fetch();
        data_processing();
        flags_and_conditions();
        load_and_store();
        branch_and_skip();
        trap_halt();
        $display("TESTS PASSED");
        $finish;
    end

endmodule
